//--- tests/intr_stimulus.txt
# op: 1 mask_wr, 2 rz_wr, 3 soft_str (bit1 ir14, bit0 ir15), 4 clm, 5 przerw, 6 done, 7 rin, 8 hw
# columns: op  w/rdt  hw  rs  bus_rz  dad  irq   (hex, irq binary, 0 = only check)
0 0000 000 000 0000 0040 0
1 ffc0 000 3ff 0000 0040 0
4 0000 000 000 0000 0040 0
1 5540 000 155 0000 0040 0
# software requests
2 4000 000 155 4000 0040 0
2 4008 000 155 4008 0040 1
3 0002 000 155 400a 0040 1
3 0001 000 155 400b 0040 1
3 0000 000 155 4008 0040 1
4 0000 000 000 0000 0040 0
# priority and nesting
1 ffc0 000 3ff 0000 0040 0
2 0448 000 3ff 0448 0040 1
5 0000 000 3c0 0048 0045 0
1 ffc0 000 3ff 0048 0045 0
2 2048 000 3ff 2048 0045 1
5 0000 000 200 0048 0042 0
1 ffc0 000 3ff 0048 0042 0
6 0000 000 3ff 0048 0045 0
6 0000 000 3ff 0048 0040 1
5 0000 000 3c0 0008 0049 0
6 0000 000 3c0 0008 0040 0
1 ffc0 000 3ff 0008 0040 1
5 0000 000 3fe 0000 005c 0
6 0000 000 3fe 0000 0040 0
4 0000 000 000 0000 0040 0
# bus interrupts
1 ffc0 000 3ff 0000 0040 0
7 0006 000 3ff 0000 0040 1
5 0000 000 3f0 0000 004f 0
6 0000 000 3f0 0000 0040 0
1 ffc0 000 3ff 0000 0040 0
7 8001 000 3ff 0004 0040 1
5 0000 000 3fe 0000 005d 0
6 0000 000 3fe 0000 0040 0
7 0001 000 3fe 1000 0040 1
5 0000 000 300 0000 0043 0
6 0000 000 300 0000 0040 0
# hardware lines
4 0000 000 000 0000 0040 0
8 0000 040 000 0400 0040 0
1 ffc0 000 3ff 0400 0040 1
5 0000 000 3c0 0000 0045 0
6 0000 000 3c0 0000 0040 0
4 0000 000 000 0000 0040 0
8 0000 400 000 8000 0040 1
5 0000 000 000 0000 0040 0
6 0000 000 000 0000 0040 0

//--- files.f
verilog/intr_pkg.sv
verilog/intr_mask.sv
verilog/intr_req.sv
verilog/intr_prio.sv
verilog/chan_resp.sv
verilog/intr_sys.sv
tests/intr_sys_tb.sv

//--- tests/intr_sys_tb.sv
module intr_sys_tb
	import intr_pkg::*;
();

	localparam int DOK_DLY_TICKS = 3; // DUT defaults
	localparam int DOK_TICKS = 4;
	localparam STIM_FILE = "tests/intr_stimulus.txt";

	// op codes in the first column of the stimulus file
	localparam int OP_MASK = 1;
	localparam int OP_RZ = 2;
	localparam int OP_SOFT = 3;
	localparam int OP_CLM = 4;
	localparam int OP_TAKE = 5;
	localparam int OP_DONE = 6;
	localparam int OP_RIN = 7;
	localparam int OP_HW = 8;

	logic clrs;
	logic rm_reset;
	hw_irq_t hw;
	logic mask_wr;
	logic rz_wr;
	logic soft_str;
	logic ir14;
	logic ir15;
	logic clm;
	logic przerw;
	logic done;
	logic rin;
	word_t w;
	word_t rdt;
	mask_t rs;
	user_rz_t bus_rz;
	logic irq;
	word_t dad;
	logic dok;

	logic [8*128-1:0] line_buf; // one text line of the stimulus file
	int pass_cnt = 0;
	int fail_cnt = 0;
	int errs = 0; // mismatches so far
	int cycles = 0;
	int limit = 0; // 0 until the file is counted

	intr_sys intr_sys_i (.*);

	always #50 clrs = ~clrs;

	// run limit of 40 cycles per file line
	always @(posedge clrs) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			$display("timeout: tests did not finish");
			$display("sim failed");
			$finish;
		end
	end

	task automatic check_mask(input mask_t got, input mask_t exp, input string tname);
		if (got !== exp) begin
			$display("Error %0t: rs expected %h got %h in %s", $time, exp, got, tname);
			errs++;
		end
	endtask

	task automatic check_rz(input user_rz_t got, input user_rz_t exp, input string tname);
		if (got !== exp) begin
			$display("Error %0t: bus_rz expected %h got %h in %s", $time, exp, got, tname);
			errs++;
		end
	endtask

	task automatic check_adr(input word_t got, input word_t exp, input string tname);
		if (got !== exp) begin
			$display("Error %0t: dad expected %h got %h in %s", $time, exp, got, tname);
			errs++;
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string sig,
		input string tname);
		if (got !== exp) begin
			$display("Error %0t: %s expected %b got %b in %s", $time, sig, exp, got, tname);
			errs++;
		end
	endtask

	task automatic count_lines(output int n);
		int fd;
		n = 0;
		fd = $fopen(STIM_FILE, "r");
		if (fd != 0) begin
			while ($fgets(line_buf, fd) != 0) n++;
			$fclose(fd);
		end
	endtask

	task automatic release_strobes();
		mask_wr <= 1'b0;
		rz_wr <= 1'b0;
		soft_str <= 1'b0;
		ir14 <= 1'b0;
		ir15 <= 1'b0;
		clm <= 1'b0;
		przerw <= 1'b0;
		done <= 1'b0;
		rin <= 1'b0;
		hw <= '0;
	endtask

	// strobe one file line for a cycle and compare once the path settles
	task automatic run_step(input int op, input logic [15:0] opnd, input logic [10:0] hw_val,
		input logic [9:0] exp_rs, input logic [15:0] exp_rz, input logic [15:0] exp_dad,
		input logic exp_irq, input string tname);
		int errs_before;
		int settle;
		int k;
		errs_before = errs;
		// hw goes through two sync flops and the edge flop
		settle = (op == OP_HW) ? 2 : ((op == OP_RIN) ? 0 : 1);
		@(posedge clrs);
		w <= opnd;
		rdt <= opnd;
		hw <= hw_irq_t'((op == OP_HW) ? hw_val : 11'h0);
		mask_wr <= (op == OP_MASK);
		rz_wr <= (op == OP_RZ);
		soft_str <= (op == OP_SOFT);
		ir14 <= (op == OP_SOFT) && opnd[1];
		ir15 <= (op == OP_SOFT) && opnd[0];
		clm <= (op == OP_CLM);
		przerw <= (op == OP_TAKE);
		done <= (op == OP_DONE);
		rin <= (op == OP_RIN);
		@(posedge clrs); // strobe taken here
		release_strobes();
		if (op == OP_RIN) begin
			// dok window counted in cycles from the rin edge
			for (k = 1; k <= DOK_DLY_TICKS + DOK_TICKS + 1; k++) begin
				@(negedge clrs);
				check_level(dok, (k >= DOK_DLY_TICKS) && (k < DOK_DLY_TICKS + DOK_TICKS),
					"dok", tname);
				@(posedge clrs);
			end
		end
		repeat (settle) @(posedge clrs); // irq is one flop behind the registers
		if (op == OP_HW) begin
			@(negedge clrs);
			check_rz(bus_rz, user_rz_t'(exp_rz), tname); // set three cycles after the rise
			@(posedge clrs); // one more for irq
		end
		@(negedge clrs);
		check_mask(rs, mask_t'(exp_rs), tname);
		check_rz(bus_rz, user_rz_t'(exp_rz), tname);
		check_adr(dad, word_t'(exp_dad), tname);
		check_level(irq, exp_irq, "irq", tname);
		if (errs == errs_before) begin
			pass_cnt++;
			$display("%s: ok", tname);
		end else begin
			fail_cnt++;
			$display("%s: mismatch", tname);
		end
	endtask

	task automatic run_file();
		int fd;
		int tnum;
		int op;
		logic [15:0] opnd;
		logic [10:0] hw_val;
		logic [9:0] exp_rs;
		logic [15:0] exp_rz;
		logic [15:0] exp_dad;
		logic exp_irq;
		tnum = 0;
		fd = $fopen(STIM_FILE, "r");
		while ($fgets(line_buf, fd) != 0) begin
			// comment lines never scan to seven fields
			if ($sscanf(line_buf, "%d %h %h %h %h %h %b", op, opnd, hw_val, exp_rs, exp_rz,
				exp_dad, exp_irq) == 7) begin
				tnum++;
				run_step(op, opnd, hw_val, exp_rs, exp_rz, exp_dad, exp_irq,
					$sformatf("test %0d op %0d", tnum, op));
			end
		end
		$fclose(fd);
	endtask

	initial begin
		clrs = 1'b0;
		rm_reset = 1'b1;
		hw = '0;
		mask_wr = 1'b0;
		rz_wr = 1'b0;
		soft_str = 1'b0;
		ir14 = 1'b0;
		ir15 = 1'b0;
		clm = 1'b0;
		przerw = 1'b0;
		done = 1'b0;
		rin = 1'b0;
		w = '0;
		rdt = '0;
		count_lines(limit);
		limit = 40 * limit;
		if (limit == 0) begin
			$display("stimulus file missing or empty");
			$display("sim failed");
			$finish;
		end else begin
			repeat (16) @(posedge clrs);
			rm_reset <= 1'b0;
			run_file();
			$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
			if (fail_cnt == 0 && pass_cnt > 0) begin
				$display("sim passed");
			end else begin
				$display("sim failed");
			end
			$finish;
		end
	end

endmodule

//--- verilog/intr_sys.sv
module intr_sys
	import intr_pkg::*;
#(
	parameter int DOK_DLY_TICKS = 3,
	parameter int DOK_TICKS = 4,
	parameter int VEC_BASE = 64
) (
	input logic clrs,
	input logic rm_reset,
	input hw_irq_t hw,
	input logic mask_wr,
	input logic rz_wr,
	input logic soft_str,
	input logic ir14,
	input logic ir15,
	input logic clm,
	input logic przerw,
	input logic done,
	input logic rin,
	input word_t w,
	input word_t rdt,
	output mask_t rs,
	output user_rz_t bus_rz,
	output logic irq,
	output word_t dad,
	output logic dok
);

	irq_vec_t en; // mask -> request
	irq_vec_t pend; // request -> priority
	irq_vec_t set_ch; // bus -> request
	logic take;
	irq_num_t take_num;

	intr_mask intr_mask_i (
		.clrs(clrs),
		.rm_reset(rm_reset),
		.mask_wr(mask_wr),
		.clm(clm),
		.w(w),
		.take(take),
		.take_num(take_num),
		.rs(rs),
		.en(en)
	);

	intr_req intr_req_i (
		.clrs(clrs),
		.rm_reset(rm_reset),
		.hw(hw),
		.rz_wr(rz_wr),
		.soft_str(soft_str),
		.ir14(ir14),
		.ir15(ir15),
		.clm(clm),
		.w(w),
		.set_ch(set_ch),
		.en(en),
		.take(take),
		.take_num(take_num),
		.pend(pend),
		.bus_rz(bus_rz)
	);

	intr_prio #(
		.VEC_BASE(VEC_BASE)
	) intr_prio_i (
		.clrs(clrs),
		.rm_reset(rm_reset),
		.pend(pend),
		.przerw(przerw),
		.done(done),
		.irq(irq),
		.take(take),
		.take_num(take_num),
		.dad(dad)
	);

	chan_resp #(
		.DOK_DLY_TICKS(DOK_DLY_TICKS),
		.DOK_TICKS(DOK_TICKS)
	) chan_resp_i (
		.clrs(clrs),
		.rm_reset(rm_reset),
		.rin(rin),
		.rdt(rdt),
		.dok(dok),
		.set_ch(set_ch)
	);

endmodule

//--- verilog/chan_resp.sv
module chan_resp
	import intr_pkg::*;
#(
	parameter int DOK_DLY_TICKS = 3, // rin edge to dok rise
	parameter int DOK_TICKS = 4 // dok width
) (
	input logic clrs,
	input logic rm_reset,
	input logic rin, // interrupt report on the bus
	input word_t rdt,
	output logic dok,
	output irq_vec_t set_ch
);

	localparam int CNT_MAX = (DOK_DLY_TICKS > DOK_TICKS) ? DOK_DLY_TICKS : DOK_TICKS;
	localparam int CNT_W = $clog2(CNT_MAX + 1);

	typedef enum logic [1:0] {
		st_idle,
		st_delay, // waiting out DOK_DLY_TICKS
		st_answer // dok high
	} resp_state_t;

	resp_state_t state;
	logic [CNT_W-1:0] cnt; // shared down-counter
	word_t rdt_q; // report captured at rin
	chan_t chan;
	logic first; // first dok cycle

	always_ff @(posedge clrs or posedge rm_reset) begin
		if (rm_reset) begin
			state <= st_idle;
			cnt <= '0;
		end else begin
			case (state)
				st_idle: if (rin) begin
					if (DOK_DLY_TICKS > 1) begin
						state <= st_delay;
						cnt <= CNT_W'(DOK_DLY_TICKS - 2); // idle->delay edge counts as one
					end else begin
						state <= st_answer;
						cnt <= CNT_W'(DOK_TICKS - 1);
					end
				end
				st_delay: if (cnt == '0) begin
					state <= st_answer;
					cnt <= CNT_W'(DOK_TICKS - 1);
				end else begin
					cnt <= cnt - 1'b1;
				end
				st_answer: if (cnt == '0) state <= st_idle; // rin in a busy window is lost
				else cnt <= cnt - 1'b1;
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clrs) begin
		if (state == st_idle && rin) rdt_q <= rdt;
	end

	assign dok = (state == st_answer);
	assign first = dok && (cnt == CNT_W'(DOK_TICKS - 1));
	assign chan = rdt_q[11:14];

	// bit 15 clear: channel n -> 12+n, set: other cpu, bit 0 picks 29 or 3
	always_comb begin
		set_ch = '0;
		if (first) begin
			if (!rdt_q[15]) set_ch[IRQ_CHAN0 + int'(chan)] = 1'b1;
			else if (rdt_q[0]) set_ch[IRQ_CPU_LO] = 1'b1;
			else set_ch[IRQ_CPU_HI] = 1'b1;
		end
	end

endmodule

//--- verilog/intr_prio.sv
module intr_prio
	import intr_pkg::*;
#(
	parameter int VEC_BASE = 64 // vector table base
) (
	input logic clrs,
	input logic rm_reset,
	input irq_vec_t pend, // masked requests
	input logic przerw, // cpu takes the interrupt
	input logic done, // return from the current handler
	output logic irq,
	output logic take,
	output irq_num_t take_num,
	output word_t dad
);

	irq_vec_t isv, isv_nxt; // in-service
	irq_vec_t cand; // pending and above everything in service
	logic cand_any;
	irq_num_t win_num; // lowest candidate
	irq_num_t srv_num; // lowest in service, 0 when none

	// priority chain, one in-service bit blocks itself and all after it
	always_comb begin
		logic blk;
		blk = 1'b0;
		for (int n = 0; n < IRQ_N; n++) begin
			blk = blk | isv[n];
			cand[n] = pend[n] & ~blk;
		end
	end

	assign cand_any = |cand;

	// walk down so the lowest number is left
	always_comb begin
		win_num = '0;
		srv_num = '0;
		for (int n = IRQ_N - 1; n >= 0; n--) begin
			if (cand[n]) win_num = irq_num_t'(n);
			if (isv[n]) srv_num = irq_num_t'(n);
		end
	end

	assign take = przerw & irq & cand_any; // cand_any guards a clm in between
	assign take_num = win_num;

	always_comb begin
		isv_nxt = isv;
		if (done) isv_nxt[srv_num] = 1'b0; // innermost handler ends
		if (take) isv_nxt[take_num] = 1'b1;
	end

	always_ff @(posedge clrs or posedge rm_reset) begin
		if (rm_reset) begin
			isv <= '0;
			irq <= 1'b0;
		end else begin
			isv <= isv_nxt;
			irq <= cand_any & ~take; // drop for a cycle after accept
		end
	end

	assign dad = word_t'(VEC_BASE + int'(srv_num)); // base when idle

endmodule

//--- verilog/intr_req.sv
module intr_req
	import intr_pkg::*;
(
	input logic clrs,
	input logic rm_reset,
	input hw_irq_t hw, // async lines
	input logic rz_wr, // software write of rz
	input logic soft_str, // software interrupt strobe
	input logic ir14,
	input logic ir15,
	input logic clm,
	input word_t w,
	input irq_vec_t set_ch, // bus responder, one-cycle pulse
	input irq_vec_t en, // expanded mask
	input logic take,
	input irq_num_t take_num,
	output irq_vec_t pend,
	output user_rz_t bus_rz
);

	hw_irq_t hw_s1, hw_s2; // two-flop sync
	hw_irq_t hw_d; // delayed copy for edge detect
	hw_irq_t hw_rise;
	irq_vec_t hw_set;
	irq_vec_t soft_set;
	irq_vec_t rz, rz_nxt;

	always_ff @(posedge clrs or posedge rm_reset) begin
		if (rm_reset) begin
			hw_s1 <= '0;
			hw_s2 <= '0;
			hw_d <= '0;
		end else begin
			hw_s1 <= hw;
			hw_s2 <= hw_s1;
			hw_d <= hw_s2;
		end
	end

	assign hw_rise = hw_s2 & ~hw_d;

	// place each line at its request number
	always_comb begin
		hw_set = '0;
		hw_set[0] = hw_rise.pout;
		hw_set[1] = hw_rise.parity;
		hw_set[2] = hw_rise.nomem;
		hw_set[4] = hw_rise.rpa;
		hw_set[5] = hw_rise.timer;
		hw_set[6] = hw_rise.illegal;
		hw_set[7] = hw_rise.fi0;
		hw_set[8] = hw_rise.fi1;
		hw_set[9] = hw_rise.fi2;
		hw_set[10] = hw_rise.fi3;
		hw_set[28] = hw_rise.oprq;
	end

	always_comb begin
		soft_set = '0;
		soft_set[IRQ_SOFT_HI] = soft_str & ir14;
		soft_set[IRQ_SOFT_LO] = soft_str & ir15;
	end

	// clears first, then every set on top, so a set wins
	always_comb begin
		rz_nxt = rz;
		if (rz_wr) begin
			rz_nxt[0:11] = w[0:11];
			rz_nxt[28:31] = w[12:15];
		end
		if (soft_str && !ir14 && !ir15) begin
			rz_nxt[IRQ_SOFT_HI] = 1'b0; // bare strobe drops both soft levels
			rz_nxt[IRQ_SOFT_LO] = 1'b0;
		end
		if (take) rz_nxt[take_num] = 1'b0; // accepted, now in service
		if (clm) rz_nxt = '0;
		rz_nxt = rz_nxt | hw_set | soft_set | set_ch;
	end

	always_ff @(posedge clrs or posedge rm_reset) begin
		if (rm_reset) rz <= '0;
		else rz <= rz_nxt;
	end

	assign pend = rz & en;
	assign bus_rz = {rz[0:11], rz[28:31]}; // channel requests stay hidden

endmodule

//--- verilog/intr_mask.sv
module intr_mask
	import intr_pkg::*;
(
	input logic clrs,
	input logic rm_reset,
	input logic mask_wr, // load rm from w
	input logic clm, // master clear
	input word_t w,
	input logic take, // accept strobe from the priority chain
	input irq_num_t take_num,
	output mask_t rs,
	output irq_vec_t en
);

	mask_t rm;
	mask_t clr_grp; // groups dropped on accept
	grp_t take_grp;

	// accepted interrupt masks its own group and everything below it
	always_comb begin
		take_grp = grp_of(take_num);
		for (int g = 0; g < MASK_W; g++) begin
			clr_grp[g] = (g >= take_grp);
		end
	end

	always_ff @(posedge clrs or posedge rm_reset) begin
		if (rm_reset) begin
			rm <= '0;
		end else if (clm) begin
			rm <= '0;
		end else if (mask_wr) begin
			rm <= w[0:MASK_W-1]; // top 10 bits
		end else if (take) begin
			rm <= rm & ~clr_grp;
		end
	end

	assign rs = rm;

	// group bits fanned out per interrupt number
	always_comb begin
		for (int n = 0; n < IRQ_N; n++) begin
			en[n] = rm[grp_of(irq_num_t'(n))];
		end
		en[0] = 1'b1; // power out ignores rm
	end

endmodule

//--- verilog/intr_pkg.sv
package intr_pkg;

	localparam int IRQ_N = 32; // interrupt numbers 0..31
	localparam int MASK_W = 10; // rm groups

	// fixed request numbers
	localparam int IRQ_CPU_HI = 3; // other cpu, high priority
	localparam int IRQ_CHAN0 = 12; // first channel interrupt
	localparam int IRQ_CPU_LO = 29; // other cpu, low priority
	localparam int IRQ_SOFT_HI = 30;
	localparam int IRQ_SOFT_LO = 31;

	typedef logic [0:IRQ_N-1] irq_vec_t; // index = interrupt number, 0 wins
	typedef logic [4:0] irq_num_t;
	typedef logic [0:MASK_W-1] mask_t; // rm, one bit per group
	typedef logic [3:0] grp_t; // group index into rm
	typedef logic [0:15] word_t; // w / rdt / dad, bit 0 is msb
	typedef logic [0:15] user_rz_t; // rz 0..11 and 28..31
	typedef logic [3:0] chan_t; // channel number from rdt[11:14]

	// asynchronous hardware sources, request number in comments
	typedef struct packed {
		logic pout; // 0 power out, never masked
		logic parity; // 1 memory parity error
		logic nomem; // 2 no memory
		logic rpa; // 4 interface power out
		logic timer; // 5
		logic illegal; // 6 illegal instruction
		logic fi0; // 7 fixed point div overflow
		logic fi1; // 8 fp underflow
		logic fi2; // 9 fp overflow
		logic fi3; // 10 div by zero / fp error
		logic oprq; // 28 operator request
	} hw_irq_t;

	// group of each interrupt number
	// number 0 sits in no group, 0 here makes an accept of it clear every group
	function automatic grp_t grp_of(input irq_num_t num);
		case (num) inside
			5'd0: grp_of = 4'd0;
			[5'd1:5'd4]: grp_of = grp_t'(num - 5'd1); // one group each
			[5'd5:5'd11]: grp_of = 4'd4;
			[5'd12:5'd13]: grp_of = 4'd5;
			[5'd14:5'd15]: grp_of = 4'd6;
			[5'd16:5'd21]: grp_of = 4'd7;
			[5'd22:5'd27]: grp_of = 4'd8;
			default: grp_of = 4'd9; // 28..31
		endcase
	endfunction

endpackage
